// ==== rtl/sfu_defs.svh ====
/*
 * SFU sizing macros: warp count, threads per warp and datapath width
 */
`ifndef SFU_DEFS_SVH
`define SFU_DEFS_SVH

// Warps per core
`define SFU_NUM_WARPS 4

// Threads per warp, also the thread-mask width
`define SFU_NUM_THREADS 4

// Operand and result width
`define SFU_XLEN 32

// Warp index width
`define SFU_WARP_BITS ($clog2(`SFU_NUM_WARPS))

`endif

// ==== rtl/sfu_isa_pkg.sv ====
/*
 * SFU instruction-side types: operation codes, warp-control kinds
 * and the two views of the request argument word
 */
package sfu_isa_pkg;

    typedef enum logic [1:0] {
        OP_CSRRW = 2'd0,
        OP_CSRRS = 2'd1,
        OP_CSRRC = 2'd2,
        OP_WCTL  = 2'd3
    } sfu_op_e;

    // Codes 2 and 3 are reserved and execute as a no-op
    typedef enum logic [1:0] {
        WCTL_TMC    = 2'd0,
        WCTL_WSPAWN = 2'd1,
        WCTL_RSVD2  = 2'd2,
        WCTL_RSVD3  = 2'd3
    } wctl_kind_e;

    typedef struct packed {
        logic [3:0]  rsvd;
        logic [11:0] addr;
    } csr_arg_t;

    typedef struct packed {
        logic [13:0] rsvd;
        wctl_kind_e  kind;
    } wctl_arg_t;

    typedef union packed {
        csr_arg_t  csr;
        wctl_arg_t wctl;
    } sfu_arg_u;

endpackage

// ==== rtl/sfu_csr_pkg.sv ====
/*
 * SFU CSR address map
 */
package sfu_csr_pkg;

    // Scratch registers, read/write
    localparam logic [11:0] CSR_SCRATCH0 = 12'h340;
    localparam logic [11:0] CSR_SCRATCH1 = 12'h341;

    // Free-running cycle count
    localparam logic [11:0] CSR_MCYCLE = 12'hB00;

    // Warp state views, read-only
    localparam logic [11:0] CSR_WARP_ID      = 12'hCC1;
    localparam logic [11:0] CSR_ACTIVE_WARPS = 12'hCC3;
    localparam logic [11:0] CSR_TMASK        = 12'hCC4;

endpackage

// ==== rtl/sfu_dispatch.sv ====
/*
 * SFU dispatch: registers an incoming request and steers it to
 * warp control or the CSR block
 */
`include "sfu_defs.svh"

module sfu_dispatch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  sfu_isa_pkg::sfu_op_e         req_op,
    input  logic [`SFU_WARP_BITS-1:0]    req_warp,
    input  sfu_isa_pkg::sfu_arg_u        req_arg,
    input  logic [`SFU_XLEN-1:0]         req_data,
    input  logic [4:0]                   req_rd,
    output logic                         wctl_req,
    output logic                         csr_req,
    output sfu_isa_pkg::sfu_op_e         exe_op,
    output logic [`SFU_WARP_BITS-1:0]    exe_warp,
    output sfu_isa_pkg::sfu_arg_u        exe_arg,
    output logic [`SFU_XLEN-1:0]         exe_data,
    output logic [4:0]                   exe_rd
);
    logic is_wctl;

    assign is_wctl = (req_op == sfu_isa_pkg::OP_WCTL);

    always_ff @(posedge clk) begin
        if (reset) begin
            wctl_req <= 1'b0;
            csr_req  <= 1'b0;
        end else begin
            wctl_req <= req_valid && is_wctl;
            csr_req  <= req_valid && !is_wctl;
        end
    end

    // Shared fields, one copy for both blocks
    always_ff @(posedge clk) begin
        exe_op   <= req_op;
        exe_warp <= req_warp;
        exe_arg  <= req_arg;
        exe_data <= req_data;
        exe_rd   <= req_rd;
    end

endmodule

// ==== rtl/sfu_wctl_unit.sv ====
/*
 * Warp control: per-warp thread masks and the active-warp mask,
 * updated by TMC and WSPAWN
 */
`include "sfu_defs.svh"

module sfu_wctl_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          wctl_req,
    input  logic [`SFU_WARP_BITS-1:0]     exe_warp,
    input  sfu_isa_pkg::sfu_arg_u         exe_arg,
    input  logic [`SFU_XLEN-1:0]          exe_data,
    input  logic [4:0]                    exe_rd,
    input  logic [`SFU_WARP_BITS-1:0]     rd_warp,
    output logic [`SFU_NUM_THREADS-1:0]   rd_tmask,
    output logic [`SFU_NUM_WARPS-1:0]     active,
    output logic                          wctl_valid,
    output logic [`SFU_WARP_BITS-1:0]     wctl_warp,
    output logic [`SFU_NUM_THREADS-1:0]   wctl_tmask,
    output logic [`SFU_NUM_WARPS-1:0]     wctl_active,
    output logic                          res_valid,
    output logic [`SFU_WARP_BITS-1:0]     res_warp,
    output logic [4:0]                    res_rd
);
    logic [`SFU_NUM_THREADS-1:0] tmask   [`SFU_NUM_WARPS];
    logic [`SFU_NUM_THREADS-1:0] tmask_n [`SFU_NUM_WARPS];
    logic [`SFU_NUM_WARPS-1:0]   active_n;
    logic [`SFU_NUM_WARPS-1:0]   spawn;
    logic                        is_tmc;
    logic                        is_wspawn;

    assign is_tmc    = wctl_req && (exe_arg.wctl.kind == sfu_isa_pkg::WCTL_TMC);
    assign is_wspawn = wctl_req && (exe_arg.wctl.kind == sfu_isa_pkg::WCTL_WSPAWN);

    // Warps that WSPAWN brings up from inactive
    assign spawn = exe_data[`SFU_NUM_WARPS-1:0] & ~active;

    // Read port for the CSR block
    assign rd_tmask = tmask[rd_warp];

    always_comb begin
        active_n = active;
        tmask_n  = tmask;
        if (is_tmc) begin
            tmask_n[exe_warp] = exe_data[`SFU_NUM_THREADS-1:0];
            if (exe_data[`SFU_NUM_THREADS-1:0] == '0) begin
                active_n[exe_warp] = 1'b0;
            end
        end
        if (is_wspawn) begin
            active_n = active | exe_data[`SFU_NUM_WARPS-1:0];
            for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
                if (spawn[w]) begin
                    tmask_n[w] = '1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= `SFU_NUM_WARPS'(1);
            wctl_valid <= 1'b0;
            res_valid  <= 1'b0;
            for (int w = 0; w < `SFU_NUM_WARPS; w++) begin
                tmask[w] <= '1;
            end
        end else begin
            active     <= active_n;
            tmask      <= tmask_n;
            wctl_valid <= is_tmc || is_wspawn;
            // Reserved kinds still commit
            res_valid  <= wctl_req;
        end
    end

    always_ff @(posedge clk) begin
        wctl_warp   <= exe_warp;
        wctl_tmask  <= tmask_n[exe_warp];
        wctl_active <= active_n;
        res_warp    <= exe_warp;
        res_rd      <= exe_rd;
    end

endmodule

// ==== rtl/sfu_csr_unit.sv ====
/*
 * CSR block beside warp control: scratch registers, cycle counter
 * and read-only views of warp state, two-cycle read/modify/write
 */
`include "sfu_defs.svh"

module sfu_csr_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          csr_req,
    input  sfu_isa_pkg::sfu_op_e          exe_op,
    input  logic [`SFU_WARP_BITS-1:0]     exe_warp,
    input  sfu_isa_pkg::sfu_arg_u         exe_arg,
    input  logic [`SFU_XLEN-1:0]          exe_data,
    input  logic [4:0]                    exe_rd,
    output logic [`SFU_WARP_BITS-1:0]     rd_warp,
    input  logic [`SFU_NUM_THREADS-1:0]   rd_tmask,
    input  logic [`SFU_NUM_WARPS-1:0]     active,
    output logic                          res_valid,
    output logic [`SFU_WARP_BITS-1:0]     res_warp,
    output logic [4:0]                    res_rd,
    output logic [`SFU_XLEN-1:0]          res_data
);
    logic [`SFU_XLEN-1:0]      scratch0;
    logic [`SFU_XLEN-1:0]      scratch1;
    logic [`SFU_XLEN-1:0]      cycle_cnt;
    logic [`SFU_XLEN-1:0]      old_val;
    logic [`SFU_XLEN-1:0]      new_val;
    logic                      s1_valid;
    logic [`SFU_WARP_BITS-1:0] s1_warp;
    logic [4:0]                s1_rd;
    logic [`SFU_XLEN-1:0]      s1_data;

    // Thread mask lookup for the requesting warp
    assign rd_warp = exe_warp;

    always_comb begin
        case (exe_arg.csr.addr)
            sfu_csr_pkg::CSR_SCRATCH0:     old_val = scratch0;
            sfu_csr_pkg::CSR_SCRATCH1:     old_val = scratch1;
            sfu_csr_pkg::CSR_MCYCLE:       old_val = cycle_cnt;
            sfu_csr_pkg::CSR_WARP_ID:      old_val = `SFU_XLEN'(exe_warp);
            sfu_csr_pkg::CSR_ACTIVE_WARPS: old_val = `SFU_XLEN'(active);
            sfu_csr_pkg::CSR_TMASK:        old_val = `SFU_XLEN'(rd_tmask);
            default:                       old_val = '0;
        endcase
    end

    always_comb begin
        case (exe_op)
            sfu_isa_pkg::OP_CSRRS: new_val = old_val | exe_data;
            sfu_isa_pkg::OP_CSRRC: new_val = old_val & ~exe_data;
            default:               new_val = exe_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scratch0  <= '0;
            scratch1  <= '0;
            cycle_cnt <= '0;
            s1_valid  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            s1_valid  <= csr_req;
            res_valid <= s1_valid;
            // Only the scratch pair is writable
            if (csr_req && exe_arg.csr.addr == sfu_csr_pkg::CSR_SCRATCH0) begin
                scratch0 <= new_val;
            end
            if (csr_req && exe_arg.csr.addr == sfu_csr_pkg::CSR_SCRATCH1) begin
                scratch1 <= new_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        s1_warp  <= exe_warp;
        s1_rd    <= exe_rd;
        s1_data  <= old_val;
        res_warp <= s1_warp;
        res_rd   <= s1_rd;
        res_data <= s1_data;
    end

endmodule

// ==== rtl/sfu_commit_arb.sv ====
/*
 * Commit arbiter: merges CSR and warp-control results in issue order,
 * CSR first, with one holding slot for a colliding warp-control result
 */
`include "sfu_defs.svh"

module sfu_commit_arb (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      csr_res_valid,
    input  logic [`SFU_WARP_BITS-1:0] csr_res_warp,
    input  logic [4:0]                csr_res_rd,
    input  logic [`SFU_XLEN-1:0]      csr_res_data,
    input  logic                      wctl_res_valid,
    input  logic [`SFU_WARP_BITS-1:0] wctl_res_warp,
    input  logic [4:0]                wctl_res_rd,
    output logic                      commit_valid,
    output logic [`SFU_WARP_BITS-1:0] commit_warp,
    output logic [4:0]                commit_rd,
    output logic                      commit_wb,
    output logic [`SFU_XLEN-1:0]      commit_data
);
    logic                      hold_valid;
    logic [`SFU_WARP_BITS-1:0] hold_warp;
    logic [4:0]                hold_rd;
    logic                      wctl_blocked;

    // A colliding CSR result or an older held entry goes out first
    assign wctl_blocked = csr_res_valid || hold_valid;

    always_comb begin
        commit_valid = csr_res_valid || hold_valid || wctl_res_valid;
        commit_warp  = wctl_res_warp;
        commit_rd    = wctl_res_rd;
        commit_wb    = 1'b0;
        commit_data  = '0;
        if (csr_res_valid) begin
            commit_warp = csr_res_warp;
            commit_rd   = csr_res_rd;
            commit_wb   = 1'b1;
            commit_data = csr_res_data;
        end else if (hold_valid) begin
            commit_warp = hold_warp;
            commit_rd   = hold_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else begin
            hold_valid <= wctl_res_valid && wctl_blocked;
        end
    end

    always_ff @(posedge clk) begin
        if (wctl_res_valid) begin
            hold_warp <= wctl_res_warp;
            hold_rd   <= wctl_res_rd;
        end
    end

endmodule

// ==== rtl/sfu_unit.sv ====
/*
 * SFU top level: dispatch, warp control, CSR block and commit arbiter
 */
`include "sfu_defs.svh"

module sfu_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    input  sfu_isa_pkg::sfu_op_e          req_op,
    input  logic [`SFU_WARP_BITS-1:0]     req_warp,
    input  sfu_isa_pkg::sfu_arg_u         req_arg,
    input  logic [`SFU_XLEN-1:0]          req_data,
    input  logic [4:0]                    req_rd,
    output logic                          commit_valid,
    output logic [`SFU_WARP_BITS-1:0]     commit_warp,
    output logic [4:0]                    commit_rd,
    output logic                          commit_wb,
    output logic [`SFU_XLEN-1:0]          commit_data,
    output logic                          wctl_valid,
    output logic [`SFU_WARP_BITS-1:0]     wctl_warp,
    output logic [`SFU_NUM_THREADS-1:0]   wctl_tmask,
    output logic [`SFU_NUM_WARPS-1:0]     wctl_active
);
    logic                        wctl_req;
    logic                        csr_req;
    sfu_isa_pkg::sfu_op_e        exe_op;
    logic [`SFU_WARP_BITS-1:0]   exe_warp;
    sfu_isa_pkg::sfu_arg_u       exe_arg;
    logic [`SFU_XLEN-1:0]        exe_data;
    logic [4:0]                  exe_rd;
    logic [`SFU_WARP_BITS-1:0]   rd_warp;
    logic [`SFU_NUM_THREADS-1:0] rd_tmask;
    logic [`SFU_NUM_WARPS-1:0]   active;
    logic                        wctl_res_valid;
    logic [`SFU_WARP_BITS-1:0]   wctl_res_warp;
    logic [4:0]                  wctl_res_rd;
    logic                        csr_res_valid;
    logic [`SFU_WARP_BITS-1:0]   csr_res_warp;
    logic [4:0]                  csr_res_rd;
    logic [`SFU_XLEN-1:0]        csr_res_data;

    sfu_dispatch dispatch (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_warp  (req_warp),
        .req_arg   (req_arg),
        .req_data  (req_data),
        .req_rd    (req_rd),
        .wctl_req  (wctl_req),
        .csr_req   (csr_req),
        .exe_op    (exe_op),
        .exe_warp  (exe_warp),
        .exe_arg   (exe_arg),
        .exe_data  (exe_data),
        .exe_rd    (exe_rd)
    );

    sfu_wctl_unit wctl_unit (
        .clk         (clk),
        .reset       (reset),
        .wctl_req    (wctl_req),
        .exe_warp    (exe_warp),
        .exe_arg     (exe_arg),
        .exe_data    (exe_data),
        .exe_rd      (exe_rd),
        .rd_warp     (rd_warp),
        .rd_tmask    (rd_tmask),
        .active      (active),
        .wctl_valid  (wctl_valid),
        .wctl_warp   (wctl_warp),
        .wctl_tmask  (wctl_tmask),
        .wctl_active (wctl_active),
        .res_valid   (wctl_res_valid),
        .res_warp    (wctl_res_warp),
        .res_rd      (wctl_res_rd)
    );

    sfu_csr_unit csr_unit (
        .clk       (clk),
        .reset     (reset),
        .csr_req   (csr_req),
        .exe_op    (exe_op),
        .exe_warp  (exe_warp),
        .exe_arg   (exe_arg),
        .exe_data  (exe_data),
        .exe_rd    (exe_rd),
        .rd_warp   (rd_warp),
        .rd_tmask  (rd_tmask),
        .active    (active),
        .res_valid (csr_res_valid),
        .res_warp  (csr_res_warp),
        .res_rd    (csr_res_rd),
        .res_data  (csr_res_data)
    );

    sfu_commit_arb commit_arb (
        .clk            (clk),
        .reset          (reset),
        .csr_res_valid  (csr_res_valid),
        .csr_res_warp   (csr_res_warp),
        .csr_res_rd     (csr_res_rd),
        .csr_res_data   (csr_res_data),
        .wctl_res_valid (wctl_res_valid),
        .wctl_res_warp  (wctl_res_warp),
        .wctl_res_rd    (wctl_res_rd),
        .commit_valid   (commit_valid),
        .commit_warp    (commit_warp),
        .commit_rd      (commit_rd),
        .commit_wb      (commit_wb),
        .commit_data    (commit_data)
    );

endmodule

// ==== tb/tb_sfu_unit.sv ====
/*
 * SFU testbench: random requests checked against a reference model,
 * with scoreboards for the in-order commit stream and warp-control strobes
 */
`include "sfu_defs.svh"

module tb_sfu_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WARP_BITS   = `SFU_WARP_BITS;
    localparam int WARPS       = `SFU_NUM_WARPS;
    localparam int THREADS     = `SFU_NUM_THREADS;
    localparam int XLEN        = `SFU_XLEN;
    localparam int NUM_REQS    = 600;
    localparam int DRAIN_LIMIT = 20;

    logic                        clk;
    logic                        reset;
    logic                        req_valid;
    sfu_isa_pkg::sfu_op_e        req_op;
    logic [WARP_BITS-1:0]        req_warp;
    sfu_isa_pkg::sfu_arg_u       req_arg;
    logic [XLEN-1:0]             req_data;
    logic [4:0]                  req_rd;
    logic                        commit_valid;
    logic [WARP_BITS-1:0]        commit_warp;
    logic [4:0]                  commit_rd;
    logic                        commit_wb;
    logic [XLEN-1:0]             commit_data;
    logic                        wctl_valid;
    logic [WARP_BITS-1:0]        wctl_warp;
    logic [THREADS-1:0]          wctl_tmask;
    logic [WARPS-1:0]            wctl_active;

    // Reference model state
    logic [XLEN-1:0]             m_scratch0;
    logic [XLEN-1:0]             m_scratch1;
    logic [WARPS-1:0]            m_active;
    logic [THREADS-1:0]          m_tmask [WARPS];
    int unsigned                 cycle_count;

    // Expected {warp, rd, wb, data} per commit, in issue order
    logic [WARP_BITS+37:0]               commit_q [$];
    // Expected {warp, tmask, active} per warp-control strobe
    logic [WARP_BITS+THREADS+WARPS-1:0]  wctl_q [$];

    int mismatches;
    int failures;
    int commits;
    int strobes;

    sfu_unit UUT (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_op       (req_op),
        .req_warp     (req_warp),
        .req_arg      (req_arg),
        .req_data     (req_data),
        .req_rd       (req_rd),
        .commit_valid (commit_valid),
        .commit_warp  (commit_warp),
        .commit_rd    (commit_rd),
        .commit_wb    (commit_wb),
        .commit_data  (commit_data),
        .wctl_valid   (wctl_valid),
        .wctl_warp    (wctl_warp),
        .wctl_tmask   (wctl_tmask),
        .wctl_active  (wctl_active)
    );

    always #50 clk = ~clk;

    task automatic compare(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic check_outputs();
        logic [WARP_BITS-1:0] e_warp;
        logic [4:0]           e_rd;
        logic                 e_wb;
        logic [XLEN-1:0]      e_data;
        logic [THREADS-1:0]   e_tmask;
        logic [WARPS-1:0]     e_active;
        if (commit_valid === 1'b1) begin
            commits++;
            if (commit_q.size() == 0) begin
                $display("Error at %0t: commit arrived with no request outstanding", $time);
                failures++;
            end else begin
                {e_warp, e_rd, e_wb, e_data} = commit_q.pop_front();
                compare("commit_warp", XLEN'(commit_warp), XLEN'(e_warp));
                compare("commit_rd", XLEN'(commit_rd), XLEN'(e_rd));
                compare("commit_wb", XLEN'(commit_wb), XLEN'(e_wb));
                compare("commit_data", commit_data, e_data);
            end
        end else if (commit_valid !== 1'b0) begin
            $display("Error at %0t: commit_valid is unknown", $time);
            failures++;
        end
        if (wctl_valid === 1'b1) begin
            strobes++;
            if (wctl_q.size() == 0) begin
                $display("Error at %0t: wctl_valid raised with no TMC or WSPAWN pending",
                         $time);
                failures++;
            end else begin
                {e_warp, e_tmask, e_active} = wctl_q.pop_front();
                compare("wctl_warp", XLEN'(wctl_warp), XLEN'(e_warp));
                compare("wctl_tmask", XLEN'(wctl_tmask), XLEN'(e_tmask));
                compare("wctl_active", XLEN'(wctl_active), XLEN'(e_active));
            end
        end else if (wctl_valid !== 1'b0) begin
            $display("Error at %0t: wctl_valid is unknown", $time);
            failures++;
        end
    endtask

    // Outputs settle well before the falling edge, inputs change right after it
    task automatic next_cycle();
        @(negedge clk);
        if (!reset) begin
            cycle_count++;
        end
        check_outputs();
        req_valid = 1'b0;
    endtask

    // Applies one request to the model and drives it for the next rising edge
    task automatic issue(input sfu_isa_pkg::sfu_op_e op, input logic [WARP_BITS-1:0] warp,
                         input logic [15:0] arg, input logic [XLEN-1:0] data,
                         input logic [4:0] rd);
        logic [11:0]      addr;
        logic [1:0]       kind;
        logic [XLEN-1:0]  old_val;
        logic [XLEN-1:0]  new_val;
        logic [WARPS-1:0] spawn;
        addr = arg[11:0];
        kind = arg[1:0];
        if (op == sfu_isa_pkg::OP_WCTL) begin
            if (kind == sfu_isa_pkg::WCTL_TMC) begin
                m_tmask[warp] = data[THREADS-1:0];
                if (data[THREADS-1:0] == '0) begin
                    m_active[warp] = 1'b0;
                end
                wctl_q.push_back({warp, m_tmask[warp], m_active});
            end else if (kind == sfu_isa_pkg::WCTL_WSPAWN) begin
                spawn = data[WARPS-1:0] & ~m_active;
                m_active = m_active | data[WARPS-1:0];
                for (int w = 0; w < WARPS; w++) begin
                    if (spawn[w]) begin
                        m_tmask[w] = '1;
                    end
                end
                wctl_q.push_back({warp, m_tmask[warp], m_active});
            end
            commit_q.push_back({warp, rd, 1'b0, XLEN'(0)});
        end else begin
            case (addr)
                sfu_csr_pkg::CSR_SCRATCH0:     old_val = m_scratch0;
                sfu_csr_pkg::CSR_SCRATCH1:     old_val = m_scratch1;
                sfu_csr_pkg::CSR_MCYCLE:       old_val = cycle_count + 1;
                sfu_csr_pkg::CSR_WARP_ID:      old_val = XLEN'(warp);
                sfu_csr_pkg::CSR_ACTIVE_WARPS: old_val = XLEN'(m_active);
                sfu_csr_pkg::CSR_TMASK:        old_val = XLEN'(m_tmask[warp]);
                default:                       old_val = '0;
            endcase
            if (op == sfu_isa_pkg::OP_CSRRS) begin
                new_val = old_val | data;
            end else if (op == sfu_isa_pkg::OP_CSRRC) begin
                new_val = old_val & ~data;
            end else begin
                new_val = data;
            end
            if (addr == sfu_csr_pkg::CSR_SCRATCH0) begin
                m_scratch0 = new_val;
            end
            if (addr == sfu_csr_pkg::CSR_SCRATCH1) begin
                m_scratch1 = new_val;
            end
            commit_q.push_back({warp, rd, 1'b1, old_val});
        end
        req_valid = 1'b1;
        req_op    = op;
        req_warp  = warp;
        req_arg   = arg;
        req_data  = data;
        req_rd    = rd;
    endtask

    // Known addresses plus a few that decode to nothing
    function automatic logic [11:0] pick_addr();
        case ($urandom() % 8)
            0:       return sfu_csr_pkg::CSR_SCRATCH0;
            1:       return sfu_csr_pkg::CSR_SCRATCH1;
            2:       return sfu_csr_pkg::CSR_MCYCLE;
            3:       return sfu_csr_pkg::CSR_WARP_ID;
            4:       return sfu_csr_pkg::CSR_ACTIVE_WARPS;
            5:       return sfu_csr_pkg::CSR_TMASK;
            6:       return 12'h342;
            default: return 12'($urandom());
        endcase
    endfunction

    initial begin
        sfu_isa_pkg::sfu_op_e op;
        logic [15:0]          arg;
        logic [XLEN-1:0]      data;
        int                   gap;
        int                   wait_count;
        void'($urandom(32'h70e9ec04));
        clk         = 1'b0;
        reset       = 1'b1;
        req_valid   = 1'b0;
        req_op      = sfu_isa_pkg::OP_CSRRW;
        req_warp    = '0;
        req_arg     = '0;
        req_data    = '0;
        req_rd      = '0;
        m_scratch0  = '0;
        m_scratch1  = '0;
        m_active    = WARPS'(1);
        cycle_count = 0;
        mismatches  = 0;
        failures    = 0;
        commits     = 0;
        strobes     = 0;
        for (int w = 0; w < WARPS; w++) begin
            m_tmask[w] = '1;
        end

        repeat (10) next_cycle();
        reset = 1'b0;
        // Idle after reset, no strobe may show up
        repeat (5) next_cycle();

        for (int n = 0; n < NUM_REQS; n++) begin
            if ($urandom() % 2 == 0) begin
                gap = 0;
            end else begin
                gap = 1 + ($urandom() % 3);
            end
            repeat (gap) next_cycle();
            next_cycle();
            case ($urandom() % 5)
                0:       op = sfu_isa_pkg::OP_CSRRW;
                1:       op = sfu_isa_pkg::OP_CSRRS;
                2:       op = sfu_isa_pkg::OP_CSRRC;
                default: op = sfu_isa_pkg::OP_WCTL;
            endcase
            if (op == sfu_isa_pkg::OP_WCTL) begin
                arg = {14'($urandom()), 2'($urandom())};
            end else begin
                arg = {4'($urandom()), pick_addr()};
            end
            // Zero operands often, so TMC deactivates warps
            if ($urandom() % 5 == 0) begin
                data = '0;
            end else begin
                data = $urandom();
            end
            issue(op, WARP_BITS'($urandom()), arg, data, 5'($urandom()));
        end

        wait_count = 0;
        while ((commit_q.size() != 0 || wctl_q.size() != 0) && wait_count < DRAIN_LIMIT) begin
            next_cycle();
            wait_count++;
        end
        if (commit_q.size() != 0 || wctl_q.size() != 0) begin
            $display("Error: timed out with %0d commits and %0d wctl strobes still missing",
                     commit_q.size(), wctl_q.size());
            failures++;
        end
        // Stray results after the drain
        repeat (4) next_cycle();

        $display("Summary: %0d commits, %0d wctl strobes, %0d mismatches, %0d other errors",
                 commits, strobes, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/sfu_isa_pkg.sv
rtl/sfu_csr_pkg.sv
rtl/sfu_dispatch.sv
rtl/sfu_wctl_unit.sv
rtl/sfu_csr_unit.sv
rtl/sfu_commit_arb.sv
rtl/sfu_unit.sv
tb/tb_sfu_unit.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_sfu_unit
FILELIST   := build.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := === PASS ===
SOURCES    := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
